//--- rtl/ccc_target_consts.svh
/*
  CCC target constants
  code values, register file addresses and data word size
*/
`ifndef CCC_TARGET_CONSTS_SVH
`define CCC_TARGET_CONSTS_SVH

// broadcast codes that carry a two byte data word
`define CCC_SETMWL_BC 8'h09 // set max write length
`define CCC_SETMRL_BC 8'h0A // set max read length

// remaining known codes, no data word on this target
`define CCC_KNOWN \
  8'h00, 8'h01, 8'h80, 8'h81, \
  8'h89, 8'h8B, 8'h8A, 8'h8C, \
  8'h90, 8'h2A, 8'h9A, 8'h8D, \
  8'h8E, 8'h8F

// register file layout
`define REGF_ADDR_W   8    // regf address width
`define REGF_MWL_BASE 8'd0 // mwl bytes at 0 and 1
`define REGF_MRL_BASE 8'd2 // mrl bytes at 2 and 3

// data word length in bytes
`define CCC_DATA_BYTES 2

`endif

//--- rtl/ccc_target_pkg.sv
/*
  CCC target types
  phy modes, request and status structs, register write and FSM states
*/
`include "ccc_target_consts.svh"

package ccc_target_pkg;

  // receive phy modes
  typedef enum logic [3:0] {
    RX_PREAMBLE    = 4'd0,
    RX_CCC_VALUE   = 4'd1,
    RX_DATA_BYTE   = 4'd2, // one byte of the data word
    RX_CMD_PARITY  = 4'd3,
    RX_DATA_PARITY = 4'd4,
    RX_TOKEN_CRC   = 4'd7,
    RX_CRC_VALUE   = 4'd8
  } rx_mode_e;

  // transmit phy modes
  typedef enum logic {
    TX_ONE_PREAMBLE  = 1'b0, // reject
    TX_ZERO_PREAMBLE = 1'b1  // accept
  } tx_mode_e;

  typedef struct packed {
    logic     en;   // one cycle request
    rx_mode_e mode; // valid with en
  } rx_req_t;

  typedef struct packed {
    logic     en;
    tx_mode_e mode;
  } tx_req_t;

  typedef struct packed {
    logic rx_done;      // pulse
    logic tx_done;      // pulse
    logic rx_error;     // with rx_done
    logic preamble_bit; // with rx_done
  } phy_status_t;

  typedef struct packed {
    logic                    wr_en;
    logic [`REGF_ADDR_W-1:0] addr;
  } regf_wr_t;

  // frame FSM states
  typedef enum logic [3:0] {
    ST_IDLE, ST_PREAMBLE, ST_ACK, ST_CCC_VALUE, ST_CMD_PARITY,
    ST_DATA, ST_DATA_PARITY, ST_TOKEN_CRC, ST_CRC_VALUE
  } frame_state_e;

endpackage

//--- rtl/ccc_code_decoder.sv
/*
  CCC code decoder
  flags known codes and the ones with a data word, gives the regf base
*/
`timescale 1ns/1ns
`include "ccc_target_consts.svh"

module ccc_code_decoder (
  input  logic [7:0]              i_ccc_value,
  output logic                    o_known,
  output logic                    o_has_data,
  output logic [`REGF_ADDR_W-1:0] o_base_addr
);

  always_comb begin
    o_known     = 1'b0; // unknown by default
    o_has_data  = 1'b0;
    o_base_addr = '0;
    case (i_ccc_value)
      `CCC_SETMWL_BC: begin
        o_known     = 1'b1;
        o_has_data  = 1'b1;
        o_base_addr = `REGF_MWL_BASE; // mwl pair
      end
      `CCC_SETMRL_BC: begin
        o_known     = 1'b1;
        o_has_data  = 1'b1;
        o_base_addr = `REGF_MRL_BASE; // mrl pair
      end
      `CCC_KNOWN: begin
        o_known = 1'b1; // parity then crc, nothing stored
      end
      default: begin
        o_known = 1'b0; // frame ends right after the code
      end
    endcase
  end

endmodule

//--- rtl/ccc_byte_counter.sv
/*
  Data byte counter
  tracks which byte of the data word is being received
*/
`timescale 1ns/1ns
`include "ccc_target_consts.svh"

module ccc_byte_counter (
  input  logic i_sys_clk,
  input  logic i_sys_rst,
  input  logic i_strobe,    // one data byte done
  input  logic i_clear,     // new code accepted
  output logic o_byte_index,
  output logic o_last_byte
);

  localparam int CNT_W = $clog2(`CCC_DATA_BYTES);
  localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`CCC_DATA_BYTES - 1);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      cnt_q <= '0;
    end else if (i_clear) begin
      cnt_q <= '0; // start of a new data word
    end else if (i_strobe) begin
      if (cnt_q == LAST_IDX)
        cnt_q <= '0; // wrap after the last byte
      else
        cnt_q <= cnt_q + 1'b1;
    end
  end

  assign o_byte_index = cnt_q;
  assign o_last_byte  = (cnt_q == LAST_IDX); // byte now in flight is the last

endmodule

//--- rtl/ccc_regf_writer.sv
/*
  Register file writer
  latches the code's base address, one write per received data byte
*/
`timescale 1ns/1ns
`include "ccc_target_consts.svh"

module ccc_regf_writer (
  input  logic                     i_sys_clk,
  input  logic                     i_sys_rst,
  input  logic                     i_code_accept,
  input  logic [`REGF_ADDR_W-1:0]  i_base_addr,
  input  logic                     i_byte_strobe,
  input  logic                     i_byte_index,
  output ccc_target_pkg::regf_wr_t o_regf_wr
);

  import ccc_target_pkg::*;

  logic [`REGF_ADDR_W-1:0] base_q; // base of the current code
  regf_wr_t                wr_q;

  // taken from the decoder on each accepted code
  always_ff @(posedge i_sys_clk) begin
    if (i_code_accept)
      base_q <= i_base_addr;
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      wr_q <= '0;
    end else begin
      wr_q.wr_en <= i_byte_strobe; // one cycle pulse
      if (i_byte_strobe)
        wr_q.addr <= base_q + `REGF_ADDR_W'(i_byte_index); // lsb first
    end
  end

  assign o_regf_wr = wr_q;

endmodule

//--- rtl/ccc_frame_fsm.sv
/*
  CCC frame FSM
  steps rx and tx phys through one frame, registered requests and done
*/
`timescale 1ns/1ns

module ccc_frame_fsm (
  input  logic                        i_sys_clk,
  input  logic                        i_sys_rst,
  input  logic                        i_engine_en,
  input  ccc_target_pkg::phy_status_t i_phy,
  input  logic                        i_known,
  input  logic                        i_has_data,
  input  logic                        i_last_byte,
  output ccc_target_pkg::rx_req_t     o_rx_req,
  output ccc_target_pkg::tx_req_t     o_tx_req,
  output logic                        o_byte_strobe, // same cycle as data rx_done
  output logic                        o_code_accept, // same cycle as code rx_done
  output logic                        o_engine_done
);

  import ccc_target_pkg::*;

  frame_state_e state_q, state_d;
  rx_req_t      rx_req_q, rx_req_d;
  tx_req_t      tx_req_q, tx_req_d;
  logic         done_q, done_d;

  always_comb begin
    state_d       = state_q;
    rx_req_d      = '0; // requests are pulses
    tx_req_d      = '0;
    done_d        = 1'b0;
    o_byte_strobe = 1'b0;
    o_code_accept = 1'b0;
    if (!i_engine_en) begin
      state_d = ST_IDLE; // silent drop, no done
    end else begin
      case (state_q)
        ST_IDLE: begin
          rx_req_d = '{en: 1'b1, mode: RX_PREAMBLE};
          state_d  = ST_PREAMBLE;
        end
        ST_PREAMBLE: if (i_phy.rx_done) begin
          if (i_phy.preamble_bit) begin
            tx_req_d = '{en: 1'b1, mode: TX_ZERO_PREAMBLE}; // ack
            state_d  = ST_ACK;
          end else begin
            done_d  = 1'b1; // not a command word
            state_d = ST_IDLE;
          end
        end
        ST_ACK: if (i_phy.tx_done) begin
          rx_req_d = '{en: 1'b1, mode: RX_CCC_VALUE};
          state_d  = ST_CCC_VALUE;
        end
        ST_CCC_VALUE: if (i_phy.rx_done) begin
          if (i_known) begin
            rx_req_d      = '{en: 1'b1, mode: RX_CMD_PARITY};
            o_code_accept = 1'b1; // writer takes base, counter clears
            state_d       = ST_CMD_PARITY;
          end else begin
            done_d  = 1'b1; // unknown code
            state_d = ST_IDLE;
          end
        end
        ST_CMD_PARITY: if (i_phy.rx_done) begin
          if (i_phy.rx_error) begin
            done_d  = 1'b1;
            state_d = ST_IDLE;
          end else if (i_has_data) begin
            rx_req_d = '{en: 1'b1, mode: RX_DATA_BYTE};
            state_d  = ST_DATA;
          end else begin
            rx_req_d = '{en: 1'b1, mode: RX_TOKEN_CRC}; // skip data word
            state_d  = ST_TOKEN_CRC;
          end
        end
        ST_DATA: if (i_phy.rx_done) begin
          o_byte_strobe = 1'b1;
          if (i_last_byte) begin
            rx_req_d = '{en: 1'b1, mode: RX_DATA_PARITY};
            state_d  = ST_DATA_PARITY;
          end else begin
            rx_req_d = '{en: 1'b1, mode: RX_DATA_BYTE}; // next byte
          end
        end
        ST_DATA_PARITY: if (i_phy.rx_done) begin
          if (i_phy.rx_error) begin
            done_d  = 1'b1;
            state_d = ST_IDLE;
          end else begin
            rx_req_d = '{en: 1'b1, mode: RX_TOKEN_CRC};
            state_d  = ST_TOKEN_CRC;
          end
        end
        ST_TOKEN_CRC: if (i_phy.rx_done) begin
          if (i_phy.rx_error) begin
            done_d  = 1'b1;
            state_d = ST_IDLE;
          end else begin
            rx_req_d = '{en: 1'b1, mode: RX_CRC_VALUE};
            state_d  = ST_CRC_VALUE;
          end
        end
        ST_CRC_VALUE: if (i_phy.rx_done) begin
          done_d  = 1'b1; // end of frame, error or not
          state_d = ST_IDLE;
        end
        default: state_d = ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
    if (!i_sys_rst) begin
      state_q  <= ST_IDLE;
      rx_req_q <= '0;
      tx_req_q <= '0;
      done_q   <= 1'b0;
    end else begin
      state_q  <= state_d;
      rx_req_q <= rx_req_d;
      tx_req_q <= tx_req_d;
      done_q   <= done_d;
    end
  end

  assign o_rx_req      = rx_req_q;
  assign o_tx_req      = tx_req_q;
  assign o_engine_done = done_q;

endmodule

//--- rtl/ccc_target.sv
/*
  CCC target engine top
  frame FSM, code decoder, byte counter and regf writer
*/
`timescale 1ns/1ns
`include "ccc_target_consts.svh"

module ccc_target (
  input  logic                        i_sys_clk,
  input  logic                        i_sys_rst,
  input  logic                        i_engine_en,
  input  ccc_target_pkg::phy_status_t i_phy,
  input  logic [7:0]                  i_ccc_value,  // held from code done to frame end
  output ccc_target_pkg::rx_req_t     o_rx_req,
  output ccc_target_pkg::tx_req_t     o_tx_req,
  output ccc_target_pkg::regf_wr_t    o_regf_wr,
  output logic                        o_engine_done
);

  logic                    known;
  logic                    has_data;
  logic [`REGF_ADDR_W-1:0] base_addr;
  logic                    byte_strobe;
  logic                    code_accept;
  logic                    byte_index;
  logic                    last_byte;

  ccc_frame_fsm u_fsm (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .i_phy         (i_phy),
    .i_known       (known),
    .i_has_data    (has_data),
    .i_last_byte   (last_byte),
    .o_rx_req      (o_rx_req),
    .o_tx_req      (o_tx_req),
    .o_byte_strobe (byte_strobe),
    .o_code_accept (code_accept),
    .o_engine_done (o_engine_done)
  );

  ccc_code_decoder u_decoder (
    .i_ccc_value (i_ccc_value),
    .o_known     (known),
    .o_has_data  (has_data),
    .o_base_addr (base_addr)
  );

  ccc_byte_counter u_counter (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_strobe     (byte_strobe),
    .i_clear      (code_accept), // fresh count per code
    .o_byte_index (byte_index),
    .o_last_byte  (last_byte)
  );

  ccc_regf_writer u_writer (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_code_accept (code_accept),
    .i_base_addr   (base_addr),
    .i_byte_strobe (byte_strobe),
    .i_byte_index  (byte_index),
    .o_regf_wr     (o_regf_wr)
  );

endmodule

//--- dv/ccc_target_checker.sv
/*
  CCC target checker
  concurrent assertions on the engine's request, write and done outputs
*/
`timescale 1ns/1ns

module ccc_target_checker (
  input logic                     i_sys_clk,
  input logic                     i_sys_rst,
  input ccc_target_pkg::rx_req_t  i_rx_req,
  input ccc_target_pkg::tx_req_t  i_tx_req,
  input ccc_target_pkg::regf_wr_t i_regf_wr,
  input logic                     i_engine_done
);

  // one phy direction per cycle
  a_single_dir: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    !(i_rx_req.en && i_tx_req.en))
    else $error("rx and tx requests high in the same cycle");

  a_done_pulse: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_engine_done |=> !i_engine_done)
    else $error("engine done longer than one cycle");

  // mwl pair at 0 and 1, mrl pair at 2 and 3
  a_wr_range: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
    i_regf_wr.wr_en |-> (i_regf_wr.addr <= 8'd3))
    else $error("register write outside address 0 to 3");

  a_quiet_rst: assert property (@(posedge i_sys_clk)
    !i_sys_rst |-> !(i_rx_req.en || i_tx_req.en || i_regf_wr.wr_en || i_engine_done))
    else $error("output active while in reset");

endmodule

//--- dv/tb_ccc_target.sv
/*
  CCC target testbench
  random phy responder, cycle model of the frame rules, compare tasks and watchdog
*/
`timescale 1ns/1ns
`include "ccc_target_consts.svh"

module tb_ccc_target;

  import ccc_target_pkg::*;

  localparam int          CLK_PERIOD  = 4;
  localparam int          RST_CYCLES  = 16;
  localparam int          NUM_FRAMES  = 300;
  localparam int          WATCHDOG_NS = (RST_CYCLES + NUM_FRAMES * 9 * 10) * CLK_PERIOD;
  localparam logic [31:0] SEED        = 32'hdfcc31b8;
  localparam logic [7:0]  KNOWN_CODES [14] = '{`CCC_KNOWN};
  localparam logic [7:0]  UNKNOWN_CODES [4] = '{8'h55, 8'h3C, 8'h7E, 8'hFF};

  typedef enum logic [3:0] {
    M_IDLE, M_PRE, M_ACK, M_CODE, M_CPAR, M_DATA, M_DPAR, M_TCRC, M_CRC
  } model_state_e;

  logic        i_sys_clk = 1'b0; // low before any process starts
  logic        i_sys_rst;
  logic        i_engine_en;
  phy_status_t i_phy;
  logic [7:0]  i_ccc_value;
  rx_req_t     o_rx_req;
  tx_req_t     o_tx_req;
  regf_wr_t    o_regf_wr;
  logic        o_engine_done;

  logic [31:0]  lfsr_q;
  int           frames;
  model_state_e m_state = M_IDLE;
  logic [7:0]   m_base;       // regf base of the accepted code
  int           m_idx;        // data byte index
  logic         m_data;       // code carries a data word
  rx_req_t      exp_rx = '0;  // outputs expected after the next edge
  tx_req_t      exp_tx = '0;
  regf_wr_t     exp_wr = '0;
  logic         exp_done = 1'b0;
  int           n_mwl_wr, n_mrl_wr, n_no_data, n_abort, n_early_end, n_drop;

  ccc_target u_dut (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_engine_en   (i_engine_en),
    .i_phy         (i_phy),
    .i_ccc_value   (i_ccc_value),
    .o_rx_req      (o_rx_req),
    .o_tx_req      (o_tx_req),
    .o_regf_wr     (o_regf_wr),
    .o_engine_done (o_engine_done)
  );

  bind ccc_target ccc_target_checker u_checker (
    .i_sys_clk     (i_sys_clk),
    .i_sys_rst     (i_sys_rst),
    .i_rx_req      (o_rx_req),
    .i_tx_req      (o_tx_req),
    .i_regf_wr     (o_regf_wr),
    .i_engine_done (o_engine_done)
  );

  always #(CLK_PERIOD / 2) i_sys_clk = ~i_sys_clk;

  // galois lfsr, one step per bit taken
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] val;
    val = '0;
    for (int k = 0; k < n; k++) begin
      val    = {val[6:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return val;
  endfunction

  function automatic logic code_known(input logic [7:0] c);
    logic hit;
    hit = (c == `CCC_SETMWL_BC) || (c == `CCC_SETMRL_BC);
    foreach (KNOWN_CODES[k])
      if (c == KNOWN_CODES[k])
        hit = 1'b1;
    return hit;
  endfunction

  // data codes half the time, rest known or unknown
  function automatic logic [7:0] pick_code();
    logic [7:0] sel;
    logic [7:0] r;
    logic [3:0] idx;
    logic [7:0] code;
    sel = rand_bits(4);
    if (sel < 8'd4) begin
      code = `CCC_SETMWL_BC;
    end else if (sel < 8'd8) begin
      code = `CCC_SETMRL_BC;
    end else if (sel < 8'd14) begin
      r   = rand_bits(4);
      idx = r[3:0];
      if (idx > 4'd13)
        idx = idx - 4'd14; // fold into the 14 entry list
      code = KNOWN_CODES[idx];
    end else begin
      r    = rand_bits(2);
      code = UNKNOWN_CODES[r[1:0]];
    end
    return code;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_rx_req(input rx_req_t act, input rx_req_t exp);
    if (act.en !== exp.en || (exp.en && act.mode !== exp.mode))
      report_mismatch($sformatf("rx request en=%0b mode=%0d, expected en=%0b mode=%0d",
                                act.en, act.mode, exp.en, exp.mode));
  endtask

  task automatic check_tx_req(input tx_req_t act, input tx_req_t exp);
    if (act.en !== exp.en || (exp.en && act.mode !== exp.mode))
      report_mismatch($sformatf("tx request en=%0b mode=%0d, expected en=%0b mode=%0d",
                                act.en, act.mode, exp.en, exp.mode));
  endtask

  task automatic check_regf_wr(input regf_wr_t act, input regf_wr_t exp);
    if (act.wr_en !== exp.wr_en || (exp.wr_en && act.addr !== exp.addr))
      report_mismatch($sformatf("regf write en=%0b addr=%0d, expected en=%0b addr=%0d",
                                act.wr_en, act.addr, exp.wr_en, exp.addr));
  endtask

  task automatic check_done(input logic act, input logic exp);
    if (act !== exp)
      report_mismatch($sformatf("engine done %0b, expected %0b", act, exp));
  endtask

  // compare last prediction, then predict the next edge from current inputs
  always @(negedge i_sys_clk) begin : model
    rx_req_t  nx_rx;
    tx_req_t  nx_tx;
    regf_wr_t nx_wr;
    logic     nx_done;
    check_rx_req(o_rx_req, exp_rx);
    check_tx_req(o_tx_req, exp_tx);
    check_regf_wr(o_regf_wr, exp_wr);
    check_done(o_engine_done, exp_done);
    nx_rx   = '0;
    nx_tx   = '0;
    nx_wr   = '0;
    nx_done = 1'b0;
    if (!i_sys_rst || !i_engine_en) begin
      m_state = M_IDLE; // reset or dropped enable, no done
    end else begin
      case (m_state)
        M_IDLE: begin
          nx_rx   = '{en: 1'b1, mode: RX_PREAMBLE};
          m_state = M_PRE;
        end
        M_PRE: if (i_phy.rx_done) begin
          if (i_phy.preamble_bit) begin
            nx_tx   = '{en: 1'b1, mode: TX_ZERO_PREAMBLE};
            m_state = M_ACK;
          end else begin
            nx_done = 1'b1;
            m_state = M_IDLE;
            n_early_end++;
          end
        end
        M_ACK: if (i_phy.tx_done) begin
          nx_rx   = '{en: 1'b1, mode: RX_CCC_VALUE};
          m_state = M_CODE;
        end
        M_CODE: if (i_phy.rx_done) begin
          if (code_known(i_ccc_value)) begin
            nx_rx   = '{en: 1'b1, mode: RX_CMD_PARITY};
            m_idx   = 0;
            m_data  = (i_ccc_value == `CCC_SETMWL_BC) || (i_ccc_value == `CCC_SETMRL_BC);
            m_base  = (i_ccc_value == `CCC_SETMRL_BC) ? `REGF_MRL_BASE : `REGF_MWL_BASE;
            m_state = M_CPAR;
          end else begin
            nx_done = 1'b1; // unknown code ends the frame
            m_state = M_IDLE;
            n_early_end++;
          end
        end
        M_CPAR, M_DPAR, M_TCRC: if (i_phy.rx_done) begin
          if (i_phy.rx_error) begin
            nx_done = 1'b1;
            m_state = M_IDLE;
            n_abort++;
          end else if (m_state == M_CPAR && m_data) begin
            nx_rx   = '{en: 1'b1, mode: RX_DATA_BYTE};
            m_state = M_DATA;
          end else if (m_state == M_TCRC) begin
            nx_rx   = '{en: 1'b1, mode: RX_CRC_VALUE};
            m_state = M_CRC;
          end else begin
            if (m_state == M_CPAR)
              n_no_data++;
            nx_rx   = '{en: 1'b1, mode: RX_TOKEN_CRC};
            m_state = M_TCRC;
          end
        end
        M_DATA: if (i_phy.rx_done) begin
          nx_wr = '{wr_en: 1'b1, addr: m_base + 8'(m_idx)}; // one write per byte
          if (m_base == `REGF_MRL_BASE)
            n_mrl_wr++;
          else
            n_mwl_wr++;
          if (m_idx == `CCC_DATA_BYTES - 1) begin
            nx_rx   = '{en: 1'b1, mode: RX_DATA_PARITY};
            m_state = M_DPAR;
          end else begin
            nx_rx = '{en: 1'b1, mode: RX_DATA_BYTE};
            m_idx++;
          end
        end
        M_CRC: if (i_phy.rx_done) begin
          nx_done = 1'b1; // end of frame either way
          m_state = M_IDLE;
        end
        default: m_state = M_IDLE;
      endcase
    end
    exp_rx   = nx_rx;
    exp_tx   = nx_tx;
    exp_wr   = nx_wr;
    exp_done = nx_done;
  end

  // answer one request after 1 to 8 cycles
  task automatic serve_request(input logic is_tx, input rx_mode_e mode);
    phy_status_t sts;
    logic [7:0]  r;
    logic [7:0]  code;
    int          delay;
    sts   = '0;
    code  = i_ccc_value; // held until the next code phase
    r     = rand_bits(3);
    delay = int'(r) + 1;
    if (is_tx) begin
      sts.tx_done = 1'b1;
    end else begin
      sts.rx_done = 1'b1;
      case (mode)
        RX_PREAMBLE: begin
          r                = rand_bits(4);
          sts.preamble_bit = (r != 8'd0); // low 1 in 16
        end
        RX_CCC_VALUE: code = pick_code();
        RX_CMD_PARITY, RX_DATA_PARITY, RX_TOKEN_CRC, RX_CRC_VALUE: begin
          r            = rand_bits(4);
          sts.rx_error = (r == 8'd0); // error 1 in 16
        end
        default: sts.rx_error = 1'b0;
      endcase
    end
    repeat (delay) @(posedge i_sys_clk);
    i_phy       <= sts;
    i_ccc_value <= code;
    @(posedge i_sys_clk);
    i_phy <= '0;
  endtask

  // pull enable low mid frame instead of answering
  task automatic drop_engine();
    @(posedge i_sys_clk);
    i_engine_en <= 1'b0;
    repeat (2) @(posedge i_sys_clk);
    i_engine_en <= 1'b1;
    n_drop++;
  endtask

  initial begin : stimulus
    rx_mode_e   mode;
    logic       is_tx;
    logic [7:0] r;
    lfsr_q      = SEED;
    i_sys_rst   = 1'b0;
    i_engine_en = 1'b1;
    i_phy       = '0;
    i_ccc_value = 8'h00;
    repeat (RST_CYCLES) @(posedge i_sys_clk);
    i_sys_rst <= 1'b1;
    while (frames < NUM_FRAMES) begin
      @(negedge i_sys_clk);
      if (o_engine_done)
        frames++;
      if (o_rx_req.en || o_tx_req.en) begin
        is_tx = o_tx_req.en;
        mode  = o_rx_req.mode;
        r     = rand_bits(6);
        if (r == 8'd0) begin
          drop_engine(); // 1 in 64 requests
          frames++;
        end else begin
          serve_request(is_tx, mode);
        end
      end
    end
    if (n_mwl_wr == 0 || n_mrl_wr == 0 || n_no_data == 0 || n_abort == 0 ||
        n_early_end == 0 || n_drop == 0) begin
      $display("not every frame kind was exercised: mwl %0d mrl %0d plain %0d abort %0d",
               n_mwl_wr, n_mrl_wr, n_no_data, n_abort);
      $display("Testbench failed");
      $fatal(1);
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d of %0d frames", frames, NUM_FRAMES);
    $display("Testbench failed");
    $fatal(1);
  end

endmodule

//--- compile.f
+incdir+rtl
rtl/ccc_target_pkg.sv
rtl/ccc_code_decoder.sv
rtl/ccc_byte_counter.sv
rtl/ccc_regf_writer.sv
rtl/ccc_frame_fsm.sv
rtl/ccc_target.sv
dv/ccc_target_checker.sv
dv/tb_ccc_target.sv

//--- Makefile
SIM       ?= verilator
TOP       ?= tb_ccc_target
FILELIST  ?= compile.f
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Testbench passed$$" $(LOG) || (echo "simulation did not pass"; exit 1)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
